/* Bender.yml */
package:
  name: uart_bus_slave

sources:
  # design, in compile order
  - uart_bus_pkg.sv
  - serial_deserializer.sv
  - read_serializer.sv
  - uart_tx.sv
  - uart_rx.sv
  - bus_slave_ctrl.sv
  - uart_bus_slave_top.sv

  # verification
  - target: test
    files:
      - uart_bus_slave_sva.sv
      - tb_uart_bus_slave.sv

/* bus_slave_ctrl.sv */
`timescale 1ns/1ps

module bus_slave_ctrl #(
    parameter int unsigned SLAVE_ID = 1
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      control,
    input  logic                      valid,
    input  uart_bus_pkg::ctrl_frame_t frame,
    input  logic                      frame_full,
    input  logic                      data_full,
    input  uart_bus_pkg::rx_byte_t    rx_byte,
    input  logic                      tx_ready,
    input  logic                      ser_active,
    output logic                      frame_shift,
    output logic                      frame_clear,
    output logic                      data_shift,
    output logic                      data_clear,
    output logic                      ser_load,
    output logic                      tx_start,
    output logic                      ready
);

    localparam int unsigned ID_W  = uart_bus_pkg::S_ID_WIDTH;
    localparam int unsigned CNT_W = $clog2(uart_bus_pkg::CTRL_LEN + 1);
    localparam logic [ID_W-1:0]  MY_ID   = ID_W'(SLAVE_ID);
    localparam logic [CNT_W-1:0] OP_BITS = CNT_W'(uart_bus_pkg::OP_WIDTH);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FRAME,
        S_WR_SEL,
        S_WR_WAIT,
        S_RD_SEL,
        S_RD_SHIFT,
        S_RD_ACK
    } state_e;

    state_e           state;
    state_e           state_nxt;
    // frame bits taken so far
    logic [CNT_W-1:0] frm_cnt;
    logic             abort_hit;

    // opcode sits in the low bits after three shifts
    assign abort_hit = (state == S_FRAME) && (frm_cnt == OP_BITS)
                     && (frame[uart_bus_pkg::OP_WIDTH-1:0] == uart_bus_pkg::OP_ABORT);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= S_IDLE;
            frm_cnt <= '0;
        end else begin
            state <= state_nxt;
            // every exit from the frame state goes through a clear
            if (frame_clear) begin
                frm_cnt <= '0;
            end else if (frame_shift) begin
                frm_cnt <= frm_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt   = state;
        frame_shift = 1'b0;
        frame_clear = 1'b0;
        data_shift  = 1'b0;
        data_clear  = 1'b0;
        ser_load    = 1'b0;
        tx_start    = 1'b0;
        ready       = 1'b1;
        case (state)
            S_IDLE: begin
                // first high control bit is already the opcode msb
                if (control) begin
                    frame_shift = 1'b1;
                    state_nxt   = S_FRAME;
                end
            end
            S_FRAME: begin
                if (abort_hit) begin
                    frame_clear = 1'b1;
                    state_nxt   = S_IDLE;
                end else if (frame_full) begin
                    frame_clear = 1'b1;
                    if (frame.op == uart_bus_pkg::OP_START && frame.slave_id == MY_ID) begin
                        state_nxt = frame.rw ? S_WR_SEL : S_RD_SEL;
                    end else begin
                        // not for us or unknown opcode
                        state_nxt = S_IDLE;
                    end
                end else begin
                    frame_shift = 1'b1;
                end
            end
            S_WR_SEL: begin
                data_shift = valid;
                if (data_full) begin
                    if (tx_ready) begin
                        tx_start   = 1'b1;
                        data_clear = 1'b1;
                        state_nxt  = S_IDLE;
                    end else begin
                        state_nxt = S_WR_WAIT;
                    end
                end
            end
            S_WR_WAIT: begin
                // byte held until the previous uart frame is out
                ready = 1'b0;
                if (tx_ready) begin
                    tx_start   = 1'b1;
                    data_clear = 1'b1;
                    state_nxt  = S_IDLE;
                end
            end
            S_RD_SEL: begin
                ready = 1'b0;
                if (rx_byte.done) begin
                    ser_load  = 1'b1;
                    state_nxt = S_RD_SHIFT;
                end
            end
            S_RD_SHIFT: begin
                ready = ser_active;
                // ack may already come in the first cycle after the byte
                if (!ser_active) begin
                    state_nxt = valid ? S_IDLE : S_RD_ACK;
                end
            end
            default: begin
                ready = 1'b0;
                if (valid) begin
                    state_nxt = S_IDLE;
                end
            end
        endcase
    end

endmodule

/* read_serializer.sv */
`timescale 1ns/1ps

module read_serializer (
    input  logic                clk,
    input  logic                rstN,
    input  logic                load,
    input  uart_bus_pkg::data_t data,
    output logic                rD,
    output logic                active
);

    localparam int unsigned CNT_W = $clog2(uart_bus_pkg::DATA_WIDTH);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(uart_bus_pkg::DATA_WIDTH - 1);

    uart_bus_pkg::data_t shreg;
    logic [CNT_W-1:0]    cnt;

    // active window is exactly one byte long
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (load) begin
            active <= 1'b1;
            cnt    <= '0;
        end else if (active) begin
            cnt <= cnt + 1'b1;
            if (cnt == LAST) begin
                active <= 1'b0;
            end
        end
    end

    // shift left, msb is the bit on the wire
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= data;
        end else if (active) begin
            shreg <= {shreg[uart_bus_pkg::DATA_WIDTH-2:0], 1'b0};
        end
    end

    // line parks low outside the window
    assign rD = active & shreg[uart_bus_pkg::DATA_WIDTH-1];

endmodule

/* serial_deserializer.sv */
`timescale 1ns/1ps

module serial_deserializer #(
    parameter type payload_t = uart_bus_pkg::data_t
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     shift_en,
    input  logic     clear,
    input  logic     bit_in,
    output payload_t word,
    output logic     full
);

    localparam int unsigned W     = $bits(payload_t);
    localparam int unsigned CNT_W = (W > 1) ? $clog2(W) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(W - 1);

    logic [W-1:0]     shreg;
    logic [CNT_W-1:0] cnt;
    // set once the word is complete, blocks further shifts
    logic             hold;

    // bit counter and full strobe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt  <= '0;
            hold <= 1'b0;
            full <= 1'b0;
        end else begin
            full <= 1'b0;
            if (clear) begin
                cnt  <= '0;
                hold <= 1'b0;
            end else if (shift_en && !hold) begin
                if (cnt == LAST) begin
                    cnt  <= '0;
                    hold <= 1'b1;
                    full <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // msb first, new bit enters at bit 0
    always_ff @(posedge clk) begin
        if (shift_en && !hold && !clear) begin
            shreg <= {shreg[W-2:0], bit_in};
        end
    end

    assign word = payload_t'(shreg);

endmodule

/* tb.f */
uart_bus_pkg.sv
serial_deserializer.sv
read_serializer.sv
uart_tx.sv
uart_rx.sv
bus_slave_ctrl.sv
uart_bus_slave_top.sv
uart_bus_slave_sva.sv
tb_uart_bus_slave.sv

/* tb_uart_bus_slave.sv */
`timescale 1ns/1ps

module tb_uart_bus_slave;

    localparam int unsigned SLAVE_ID     = 1;
    localparam int unsigned CLKS_PER_BIT = 4;
    localparam int unsigned UART_BITS    = 10;
    // 20 frames of 12 bit times plus margin
    localparam int unsigned TIMEOUT_CYCLES = 20 * 12 * CLKS_PER_BIT + 2000;
    localparam logic [uart_bus_pkg::S_ID_WIDTH-1:0] MY_ID    =
        uart_bus_pkg::S_ID_WIDTH'(SLAVE_ID);
    localparam logic [uart_bus_pkg::S_ID_WIDTH-1:0] OTHER_ID = 2'd2;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic uart_rxd;
    logic rD;
    logic ready;
    logic uart_txd;

    int unsigned rnd_state = 33;
    int unsigned cycles    = 0;

    uart_bus_slave_top #(
        .SLAVE_ID     (SLAVE_ID),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) DUT (
        .clk      (clk),
        .rstN     (rstN),
        .control  (control),
        .wD       (wD),
        .valid    (valid),
        .uart_rxd (uart_rxd),
        .rD       (rD),
        .ready    (ready),
        .uart_txd (uart_txd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish");
            stop_on_error();
        end
    end

    // watch the bound checker
    always @(negedge clk) begin
        if (DUT.u_sva.fail_count != 0) begin
            $display("bound assertion failed at %0t", $time);
            stop_on_error();
        end
    end

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    // lcg, upper bits are the useful ones
    function automatic int unsigned next_random();
        rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
        return rnd_state;
    endfunction

    function automatic uart_bus_pkg::data_t random_byte();
        int unsigned r;
        r = next_random();
        return r[31:24];
    endfunction

    task automatic check_byte(input uart_bus_pkg::data_t got, input uart_bus_pkg::data_t exp,
                              input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %02h, expected %02h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // control frame msb first, abort stops after the opcode
    task automatic send_frame(input uart_bus_pkg::op_e op,
                              input logic [uart_bus_pkg::S_ID_WIDTH-1:0] id, input logic rw);
        uart_bus_pkg::ctrl_frame_t f;
        logic [uart_bus_pkg::CTRL_LEN-1:0] bits;
        int n;
        f.op       = op;
        f.slave_id = id;
        f.rw       = rw;
        bits       = f;
        n = (op == uart_bus_pkg::OP_ABORT) ? uart_bus_pkg::OP_WIDTH : uart_bus_pkg::CTRL_LEN;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            control <= bits[uart_bus_pkg::CTRL_LEN-1-i];
        end
        @(posedge clk);
        control <= 1'b0;
        // controller decision cycle
        @(posedge clk);
    endtask

    // msb first, random valid gaps
    task automatic shift_write(input uart_bus_pkg::data_t b);
        int unsigned gap;
        for (int i = uart_bus_pkg::DATA_WIDTH - 1; i >= 0; i--) begin
            gap = (next_random() >> 20) % 2;
            repeat (gap) begin
                @(posedge clk);
                valid <= 1'b0;
            end
            @(posedge clk);
            valid <= 1'b1;
            wD    <= b[i];
        end
        @(posedge clk);
        valid <= 1'b0;
        wD    <= 1'b0;
    endtask

    task automatic uart_send(input uart_bus_pkg::data_t b);
        logic [UART_BITS-1:0] frm;
        // stop, data, start, sent from bit 0 up
        frm = {1'b1, b, 1'b0};
        for (int i = 0; i < UART_BITS; i++) begin
            @(posedge clk);
            uart_rxd <= frm[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic uart_capture(output uart_bus_pkg::data_t b);
        @(negedge clk);
        // hunt for the start bit
        while (uart_txd !== 1'b0) @(negedge clk);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        check_level(uart_txd, 1'b0, "uart_txd start bit");
        for (int i = 0; i < uart_bus_pkg::DATA_WIDTH; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = uart_txd;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_level(uart_txd, 1'b1, "uart_txd stop bit");
    endtask

    task automatic read_rD(output uart_bus_pkg::data_t b);
        @(negedge clk);
        while (ready !== 1'b1) @(negedge clk);
        for (int i = uart_bus_pkg::DATA_WIDTH - 1; i >= 0; i--) begin
            check_level(ready, 1'b1, "ready in read window");
            b[i] = rD;
            @(negedge clk);
        end
        check_level(ready, 1'b0, "ready after eight read bits");
    endtask

    task automatic ack_pulse();
        @(posedge clk);
        valid <= 1'b1;
        @(posedge clk);
        valid <= 1'b0;
    endtask

    // let the uart line go quiet between tests
    task automatic settle_line();
        repeat (2 * CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic verify_reset_values();
        @(negedge clk);
        check_level(ready, 1'b1, "ready after reset");
        check_level(rD, 1'b0, "rD after reset");
        check_level(uart_txd, 1'b1, "uart_txd after reset");
    endtask

    task automatic write_one_byte();
        uart_bus_pkg::data_t exp;
        uart_bus_pkg::data_t got;
        exp = random_byte();
        send_frame(uart_bus_pkg::OP_START, MY_ID, 1'b1);
        shift_write(exp);
        uart_capture(got);
        check_byte(got, exp, "written byte on uart_txd");
    endtask

    task automatic read_one_byte();
        uart_bus_pkg::data_t exp;
        uart_bus_pkg::data_t got;
        exp = random_byte();
        send_frame(uart_bus_pkg::OP_START, MY_ID, 1'b0);
        @(negedge clk);
        check_level(ready, 1'b0, "ready while waiting for uart byte");
        uart_send(exp);
        read_rD(got);
        check_byte(got, exp, "byte read on rD");
        ack_pulse();
        @(negedge clk);
        check_level(ready, 1'b1, "ready after read ack");
    endtask

    task automatic ignore_other_id();
        send_frame(uart_bus_pkg::OP_START, OTHER_ID, 1'b1);
        shift_write(random_byte());
        // three frame times of idle line
        repeat (3 * UART_BITS * CLKS_PER_BIT) begin
            @(negedge clk);
            check_level(uart_txd, 1'b1, "uart_txd after frame for other id");
        end
        check_level(ready, 1'b1, "ready after frame for other id");
    endtask

    task automatic abort_then_write();
        uart_bus_pkg::data_t exp;
        uart_bus_pkg::data_t got;
        exp = random_byte();
        send_frame(uart_bus_pkg::OP_ABORT, MY_ID, 1'b1);
        send_frame(uart_bus_pkg::OP_START, MY_ID, 1'b1);
        shift_write(exp);
        uart_capture(got);
        check_byte(got, exp, "byte written after abort");
    endtask

    task automatic write_back_to_back();
        uart_bus_pkg::data_t exp_a;
        uart_bus_pkg::data_t exp_b;
        uart_bus_pkg::data_t got_a;
        uart_bus_pkg::data_t got_b;
        exp_a = random_byte();
        exp_b = random_byte();
        fork
            begin
                send_frame(uart_bus_pkg::OP_START, MY_ID, 1'b1);
                shift_write(exp_a);
                send_frame(uart_bus_pkg::OP_START, MY_ID, 1'b1);
                shift_write(exp_b);
                // second byte parked behind the first uart frame
                repeat (2) @(negedge clk);
                check_level(ready, 1'b0, "ready while byte waits for transmitter");
            end
            begin
                uart_capture(got_a);
                uart_capture(got_b);
            end
        join
        check_byte(got_a, exp_a, "first back-to-back byte");
        check_byte(got_b, exp_b, "second back-to-back byte");
    endtask

    initial begin
        rstN     = 1'b0;
        control  = 1'b0;
        wD       = 1'b0;
        valid    = 1'b0;
        uart_rxd = 1'b1;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        verify_reset_values();
        write_one_byte();
        settle_line();
        read_one_byte();
        settle_line();
        ignore_other_id();
        settle_line();
        abort_then_write();
        settle_line();
        write_back_to_back();
        settle_line();
        if (DUT.u_sva.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("bound assertion failed during the run");
            stop_on_error();
        end
    end

endmodule

/* uart_bus_pkg.sv */
package uart_bus_pkg;

    // bus data word, same as one uart character
    localparam int unsigned DATA_WIDTH = 8;

    // control frame layout: opcode | slave id | rw
    localparam int unsigned S_ID_WIDTH = 2;
    localparam int unsigned OP_WIDTH   = 3;
    localparam int unsigned CTRL_LEN   = OP_WIDTH + S_ID_WIDTH + 1;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // only start and abort are decoded
    typedef enum logic [OP_WIDTH-1:0] {
        OP_ABORT = 3'b100,
        OP_START = 3'b111
    } op_e;

    // first bit on the wire lands in op msb
    typedef struct packed {
        op_e                   op;
        logic [S_ID_WIDTH-1:0] slave_id;
        // 1 = write to uart, 0 = read from uart
        logic                  rw;
    } ctrl_frame_t;

    // receiver output
    // done is a one-cycle strobe, data stays until the next byte
    typedef struct packed {
        logic  done;
        data_t data;
    } rx_byte_t;

    // transmitter request
    // start is a one-cycle strobe, data sampled with it
    typedef struct packed {
        logic  start;
        data_t data;
    } tx_req_t;

endpackage

/* uart_bus_slave_sva.sv */
`timescale 1ns/1ps

module uart_bus_slave_sva (
    input logic       clk,
    input logic       rstN,
    input logic       tx_start,
    input logic       tx_ready,
    input logic       uart_txd,
    input logic       ready,
    input logic       rx_done,
    input logic [2:0] ctrl_state
);

    // read-select in the controller state encoding
    localparam logic [2:0] ST_RD_SEL = 3'd4;

    // failures so far, polled by the testbench
    int unsigned fail_count = 0;

    // start strobe only towards an idle transmitter
    a_start_when_ready: assert property (
        @(posedge clk) disable iff (!rstN) tx_start |-> tx_ready
    ) else begin
        $error("tx start issued while the transmitter is busy");
        fail_count++;
    end

    // idle line stays high
    a_idle_line_high: assert property (
        @(posedge clk) disable iff (!rstN) tx_ready |-> uart_txd
    ) else begin
        $error("uart_txd low while the transmitter is idle");
        fail_count++;
    end

    a_no_ready_before_rx: assert property (
        @(posedge clk) disable iff (!rstN) (ctrl_state == ST_RD_SEL && !rx_done) |-> !ready
    ) else begin
        $error("ready high in read-select before a uart byte arrived");
        fail_count++;
    end

endmodule

bind uart_bus_slave_top uart_bus_slave_sva u_sva (
    .clk        (clk),
    .rstN       (rstN),
    .tx_start   (tx_start),
    .tx_ready   (tx_ready),
    .uart_txd   (uart_txd),
    .ready      (ready),
    .rx_done    (rx_byte.done),
    .ctrl_state (u_ctrl.state)
);

/* uart_bus_slave_top.sv */
`timescale 1ns/1ps

module uart_bus_slave_top #(
    parameter int unsigned SLAVE_ID     = 1,
    parameter int unsigned CLKS_PER_BIT = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic uart_rxd,
    output logic rD,
    output logic ready,
    output logic uart_txd
);

    uart_bus_pkg::ctrl_frame_t frame;
    uart_bus_pkg::data_t       data_word;
    uart_bus_pkg::rx_byte_t    rx_byte;
    uart_bus_pkg::tx_req_t     tx_req;

    logic frame_full;
    logic frame_shift;
    logic frame_clear;
    logic data_full;
    logic data_shift;
    logic data_clear;
    logic ser_load;
    logic ser_active;
    logic tx_start;
    logic tx_ready;

    // start strobe from the FSM, payload straight from the write shifter
    assign tx_req.start = tx_start;
    assign tx_req.data  = data_word;

    bus_slave_ctrl #(
        .SLAVE_ID (SLAVE_ID)
    ) u_ctrl (
        .clk         (clk),
        .rstN        (rstN),
        .control     (control),
        .valid       (valid),
        .frame       (frame),
        .frame_full  (frame_full),
        .data_full   (data_full),
        .rx_byte     (rx_byte),
        .tx_ready    (tx_ready),
        .ser_active  (ser_active),
        .frame_shift (frame_shift),
        .frame_clear (frame_clear),
        .data_shift  (data_shift),
        .data_clear  (data_clear),
        .ser_load    (ser_load),
        .tx_start    (tx_start),
        .ready       (ready)
    );

    // control frames from the bus
    serial_deserializer #(
        .payload_t (uart_bus_pkg::ctrl_frame_t)
    ) u_frame_des (
        .clk      (clk),
        .rstN     (rstN),
        .shift_en (frame_shift),
        .clear    (frame_clear),
        .bit_in   (control),
        .word     (frame),
        .full     (frame_full)
    );

    // write data byte from the bus
    serial_deserializer #(
        .payload_t (uart_bus_pkg::data_t)
    ) u_data_des (
        .clk      (clk),
        .rstN     (rstN),
        .shift_en (data_shift),
        .clear    (data_clear),
        .bit_in   (wD),
        .word     (data_word),
        .full     (data_full)
    );

    read_serializer u_read_ser (
        .clk    (clk),
        .rstN   (rstN),
        .load   (ser_load),
        .data   (rx_byte.data),
        .rD     (rD),
        .active (ser_active)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .clk      (clk),
        .rstN     (rstN),
        .req      (tx_req),
        .txd      (uart_txd),
        .tx_ready (tx_ready)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_rx (
        .clk     (clk),
        .rstN    (rstN),
        .rxd     (uart_rxd),
        .rx_byte (rx_byte)
    );

endmodule

/* uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int unsigned CLKS_PER_BIT = 4
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   rxd,
    output uart_bus_pkg::rx_byte_t rx_byte
);

    localparam int unsigned CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [2:0]       LAST_BIT = 3'(uart_bus_pkg::DATA_WIDTH - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e           state;
    logic                rxd_meta;
    logic                rxd_s;
    logic                rxd_prev;
    logic [CNT_W-1:0]    baud_cnt;
    logic [2:0]          bit_idx;
    uart_bus_pkg::data_t shreg;
    logic                done;

    // two-flop synchronizer, idle line is high
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
            rxd_prev <= rxd_s;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    // falling edge on the line
                    if (rxd_prev && !rxd_s) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    baud_cnt <= baud_cnt + 1'b1;
                    if (baud_cnt == HALF_END) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        // glitch if the line is back high mid start bit
                        state    <= rxd_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    baud_cnt <= baud_cnt + 1'b1;
                    if (baud_cnt == BIT_END) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    baud_cnt <= baud_cnt + 1'b1;
                    if (baud_cnt == BIT_END) begin
                        // framing error drops the byte silently
                        done  <= rxd_s;
                        state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // lsb first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && baud_cnt == BIT_END) begin
            shreg <= {rxd_s, shreg[uart_bus_pkg::DATA_WIDTH-1:1]};
        end
    end

    assign rx_byte.done = done;
    assign rx_byte.data = shreg;

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int unsigned CLKS_PER_BIT = 4
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  uart_bus_pkg::tx_req_t req,
    output logic                  txd,
    output logic                  tx_ready
);

    localparam int unsigned CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);
    // start, 8 data, stop
    localparam logic [3:0] STOP_IDX = 4'(uart_bus_pkg::DATA_WIDTH + 1);

    logic             busy;
    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_idx;
    // remaining data bits plus stop bit, lsb goes out next
    logic [uart_bus_pkg::DATA_WIDTH:0] shreg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy     <= 1'b0;
            txd      <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else if (!busy) begin
            // start strobe ignored while a frame is on the line
            if (req.start) begin
                busy     <= 1'b1;
                txd      <= 1'b0;
                baud_cnt <= '0;
                bit_idx  <= '0;
            end
        end else if (baud_cnt == BIT_END) begin
            baud_cnt <= '0;
            if (bit_idx == STOP_IDX) begin
                // stop bit done, line already high
                busy <= 1'b0;
            end else begin
                txd     <= shreg[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // data latched with the start strobe
    always_ff @(posedge clk) begin
        if (!busy && req.start) begin
            shreg <= {1'b1, req.data};
        end else if (busy && baud_cnt == BIT_END) begin
            // ones fill in from the top
            shreg <= {1'b1, shreg[uart_bus_pkg::DATA_WIDTH:1]};
        end
    end

    assign tx_ready = ~busy;

endmodule
